// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_sram_axi
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := CHECKS FAILED
PASS_MSG  := ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: src/axi_lite_ctrl.sv
`include "sram_axi_defines.svh"

module axi_lite_ctrl (
    input  logic                    clk,
    input  logic                    rst,

    // Write address and data, accepted together
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [`SRAM_ADDR_W-1:0] awaddr,
    input  logic                    wvalid,
    output logic                    wready,
    input  logic [`SRAM_DATA_W-1:0] wdata,
    input  logic [`SRAM_STRB_W-1:0] wstrb,

    // Write response
    output logic                    bvalid,
    input  logic                    bready,
    output logic [1:0]              bresp,

    // Read address and data
    input  logic                    arvalid,
    output logic                    arready,
    input  logic [`SRAM_ADDR_W-1:0] araddr,
    output logic                    rvalid,
    input  logic                    rready,
    output logic [`SRAM_DATA_W-1:0] rdata,
    output logic [1:0]              rresp,

    sram_req_if.ctrl                bus
);

    sram_axi_pkg::ctrl_state_e state;

    logic ready_q;      // Shared by all three ready outputs
    logic wr_acc;       // Write handshake this edge
    logic rd_acc;       // Read handshake this edge
    logic res_wr;       // Write access finishing
    logic res_rd;       // Read access finishing

    // Writes win when both channels request at once
    assign wr_acc = ready_q && (state == sram_axi_pkg::ST_IDLE) && awvalid && wvalid;
    assign rd_acc = ready_q && (state == sram_axi_pkg::ST_IDLE) && arvalid && !wr_acc;

    // Result pulse split by the opcode still held on the bus
    assign res_wr = (state == sram_axi_pkg::ST_WAIT) && bus.res_valid &&
                    (bus.op == sram_axi_pkg::OP_WRITE);
    assign res_rd = (state == sram_axi_pkg::ST_WAIT) && bus.res_valid &&
                    (bus.op == sram_axi_pkg::OP_READ);

    assign awready = ready_q;
    assign wready  = ready_q;
    assign arready = ready_q;

    // Control FSM and handshake flags
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state         <= sram_axi_pkg::ST_IDLE;
            ready_q       <= 1'b0;                    // Readies rise one edge after reset
            bus.req_valid <= 1'b0;
            bvalid        <= 1'b0;
            rvalid        <= 1'b0;
            bresp         <= sram_axi_pkg::RESP_OKAY;
            rresp         <= sram_axi_pkg::RESP_OKAY;
        end else begin
            // Request pulse in the cycle after acceptance
            bus.req_valid <= wr_acc || rd_acc;

            case (state)
                sram_axi_pkg::ST_IDLE: begin
                    if (wr_acc || rd_acc) begin
                        state   <= sram_axi_pkg::ST_WAIT;
                        ready_q <= 1'b0;              // One request at a time
                    end else begin
                        ready_q <= 1'b1;
                    end
                end

                sram_axi_pkg::ST_WAIT: begin
                    if (res_wr) begin
                        bvalid <= 1'b1;
                        bresp  <= bus.res_err ? sram_axi_pkg::RESP_SLVERR
                                              : sram_axi_pkg::RESP_OKAY;
                        state  <= sram_axi_pkg::ST_WRESP;
                    end else if (res_rd) begin
                        rvalid <= 1'b1;
                        rresp  <= bus.res_err ? sram_axi_pkg::RESP_SLVERR
                                              : sram_axi_pkg::RESP_OKAY;
                        state  <= sram_axi_pkg::ST_RRESP;
                    end
                end

                // Hold B until the master takes it
                sram_axi_pkg::ST_WRESP: begin
                    if (bready) begin
                        bvalid  <= 1'b0;
                        ready_q <= 1'b1;
                        state   <= sram_axi_pkg::ST_IDLE;
                    end
                end

                // Hold R until the master takes it
                sram_axi_pkg::ST_RRESP: begin
                    if (rready) begin
                        rvalid  <= 1'b0;
                        ready_q <= 1'b1;
                        state   <= sram_axi_pkg::ST_IDLE;
                    end
                end

                default: state <= sram_axi_pkg::ST_IDLE;
            endcase
        end
    end

    // Captured request fields and read data
    always_ff @(posedge clk) begin
        if (wr_acc) begin
            bus.op    <= sram_axi_pkg::OP_WRITE;
            bus.addr  <= awaddr;
            bus.wdata <= wdata;
            bus.wmask <= wstrb;
        end else if (rd_acc) begin
            bus.op   <= sram_axi_pkg::OP_READ;
            bus.addr <= araddr;                       // Write data left as is
        end
        if (res_rd) begin
            rdata <= bus.rdata;                       // Stable while rvalid is up
        end
    end

    // Request is a pulse, never two cycles long
    a_req_pulse: assert property (
        @(posedge clk) disable iff (rst) bus.req_valid |=> !bus.req_valid
    );

    // Only one response channel active
    a_resp_excl: assert property (
        @(posedge clk) disable iff (rst) !(bvalid && rvalid)
    );

    // B response held under back-pressure
    a_bresp_stable: assert property (
        @(posedge clk) disable iff (rst) (bvalid && !bready) |=> (bvalid && $stable(bresp))
    );

endmodule

// File: src/sram_array.sv
`include "sram_axi_defines.svh"

module sram_array (
    input logic     clk,
    input logic     rst,
    sram_req_if.mem bus
);

    localparam int IDX_W = $clog2(`SRAM_DEPTH);

    logic [`SRAM_DATA_W-1:0] mem [`SRAM_DEPTH];   // Word storage

    logic [IDX_W-1:0] idx;        // Word index from byte address
    logic             in_range;
    logic             is_write;

    assign idx      = bus.addr[IDX_W+1:2];        // Low two bits select a byte
    // Anything above the top word is out of range
    assign in_range = (bus.addr[`SRAM_ADDR_W-1:IDX_W+2] == '0);
    assign is_write = (bus.op == sram_axi_pkg::OP_WRITE);

    // Byte-masked write
    always_ff @(posedge clk) begin
        if (bus.req_valid && is_write && in_range) begin
            for (int b = 0; b < `SRAM_STRB_W; b++) begin
                if (bus.wmask[b]) begin
                    mem[idx][b*8 +: 8] <= bus.wdata[b*8 +: 8];
                end
            end
        end
    end

    // Result registers, updated only on a request
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bus.rdata   <= '0;
            bus.res_err <= 1'b0;
        end else if (bus.req_valid) begin
            bus.res_err <= !in_range;
            // Zero for writes and bad reads
            if (!is_write && in_range) begin
                bus.rdata <= mem[idx];
            end else begin
                bus.rdata <= '0;
            end
        end
    end

endmodule

// File: src/sram_axi_defines.svh
`ifndef SRAM_AXI_DEFINES_SVH
`define SRAM_AXI_DEFINES_SVH

// AXI address and data widths
`define SRAM_ADDR_W 32
`define SRAM_DATA_W 32
`define SRAM_STRB_W (`SRAM_DATA_W / 8)    // One strobe bit per byte

`define SRAM_DEPTH 256                     // Words in the array
`define SRAM_LATENCY 3                     // Request pulse to result-valid, at least 1
`define SRAM_CNT_W 2                       // Must hold SRAM_LATENCY

`endif

// File: src/sram_axi_pkg.sv
package sram_axi_pkg;

    // Controller FSM
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,    // Ready for a new request
        ST_WAIT  = 2'd1,    // Access in flight
        ST_WRESP = 2'd2,    // B channel held
        ST_RRESP = 2'd3     // R channel held
    } ctrl_state_e;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } sram_op_e;

    // AXI response codes, EXOKAY and DECERR unused
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_e;

endpackage

// File: src/sram_axi_top.sv
`include "sram_axi_defines.svh"

module sram_axi_top (
    input  logic                    clk,
    input  logic                    rst,

    // AXI4-Lite write channels
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [`SRAM_ADDR_W-1:0] awaddr,
    input  logic                    wvalid,
    output logic                    wready,
    input  logic [`SRAM_DATA_W-1:0] wdata,
    input  logic [`SRAM_STRB_W-1:0] wstrb,
    output logic                    bvalid,
    input  logic                    bready,
    output logic [1:0]              bresp,

    // AXI4-Lite read channels
    input  logic                    arvalid,
    output logic                    arready,
    input  logic [`SRAM_ADDR_W-1:0] araddr,
    output logic                    rvalid,
    input  logic                    rready,
    output logic [`SRAM_DATA_W-1:0] rdata,
    output logic [1:0]              rresp
);

    sram_req_if req_bus ();    // Controller, timer and array share it

    axi_lite_ctrl ctrl_i (
        .clk     (clk),
        .rst     (rst),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp),
        .bus     (req_bus.ctrl)
    );

    // Fixed access delay model
    sram_latency_timer timer_i (
        .clk (clk),
        .rst (rst),
        .bus (req_bus.timer)
    );

    sram_array array_i (
        .clk (clk),
        .rst (rst),
        .bus (req_bus.mem)
    );

endmodule

// File: src/sram_latency_timer.sv
`include "sram_axi_defines.svh"

module sram_latency_timer (
    input logic       clk,
    input logic       rst,
    sram_req_if.timer bus
);

    localparam logic [`SRAM_CNT_W-1:0] LOAD_VAL = `SRAM_LATENCY;
    localparam logic [`SRAM_CNT_W-1:0] LAST_VAL = 1;

    logic [`SRAM_CNT_W-1:0] cnt;    // Zero when idle

    // Down-counter started by the request pulse
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (bus.req_valid) begin
            cnt <= LOAD_VAL;
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;       // Parks at zero after the last step
        end
    end

    // Last count marks the end of the access
    assign bus.res_valid = (cnt == LAST_VAL);

    // Controller never overlaps two accesses
    a_no_overlap: assert property (
        @(posedge clk) disable iff (rst) bus.req_valid |-> (cnt == '0)
    );

endmodule

// File: src/sram_req_if.sv
`include "sram_axi_defines.svh"

interface sram_req_if;

    // Request side, registered in the controller
    logic                    req_valid;    // Single-cycle pulse
    sram_axi_pkg::sram_op_e  op;
    logic [`SRAM_ADDR_W-1:0] addr;         // Byte address
    logic [`SRAM_DATA_W-1:0] wdata;
    logic [`SRAM_STRB_W-1:0] wmask;

    // Result side
    logic [`SRAM_DATA_W-1:0] rdata;        // Held until next request
    logic                    res_err;      // Address out of range
    logic                    res_valid;    // End of access pulse from timer

    modport ctrl (
        output req_valid, op, addr, wdata, wmask,
        input  rdata, res_err, res_valid
    );

    modport timer (
        input  req_valid,
        output res_valid
    );

    modport mem (
        input  req_valid, op, addr, wdata, wmask,
        output rdata, res_err
    );

endinterface

// File: testbench/tb_sram_axi.sv
`include "sram_axi_defines.svh"

module tb_sram_axi;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          TIMEOUT  = 50;                 // Cycles allowed per wait loop
    localparam logic [31:0] TOP_BYTE = `SRAM_DEPTH * 4;    // First out-of-range byte address

    logic                    clk;
    logic                    rst;
    logic                    awvalid, awready, wvalid, wready, bvalid, bready;
    logic                    arvalid, arready, rvalid, rready;
    logic [`SRAM_ADDR_W-1:0] awaddr, araddr;
    logic [`SRAM_DATA_W-1:0] wdata, rdata;
    logic [`SRAM_STRB_W-1:0] wstrb;
    logic [1:0]              bresp, rresp;

    logic [31:0] ref_mem [int unsigned];    // Expected array contents by word index
    logic [1:0]  exp_bresp_q [$];
    logic [31:0] exp_rdata_q [$];
    logic [1:0]  exp_rresp_q [$];
    logic [1:0]  exp_b, exp_rr, b_hold_resp, r_hold_resp;
    logic [31:0] exp_rd, r_hold_data;
    logic        b_stall, r_stall;          // Response held low-ready last edge
    int          checks, errors, test_errs;

    sram_axi_top dut_i (
        .clk (clk), .rst (rst),
        .awvalid (awvalid), .awready (awready), .awaddr (awaddr),
        .wvalid (wvalid), .wready (wready), .wdata (wdata), .wstrb (wstrb),
        .bvalid (bvalid), .bready (bready), .bresp (bresp),
        .arvalid (arvalid), .arready (arready), .araddr (araddr),
        .rvalid (rvalid), .rready (rready), .rdata (rdata), .rresp (rresp)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;                   // 8 ns period

    // Expected outcome of one access and model update for in-range writes
    function automatic void model_access(
        input  logic        is_wr,
        input  logic [31:0] addr,
        input  logic [31:0] data,
        input  logic [3:0]  strb,
        output logic [31:0] exp_data,
        output logic [1:0]  exp_resp
    );
        int unsigned idx;
        logic [31:0] word;
        idx      = addr >> 2;
        exp_data = '0;
        exp_resp = sram_axi_pkg::RESP_OKAY;
        if (addr >= TOP_BYTE) begin
            exp_resp = sram_axi_pkg::RESP_SLVERR;    // Nothing stored and reads give zero
        end else begin
            word = ref_mem.exists(idx) ? ref_mem[idx] : '0;
            if (is_wr) begin
                for (int b = 0; b < 4; b++) begin
                    if (strb[b]) begin
                        word[b*8 +: 8] = data[b*8 +: 8];    // Byte merge
                    end
                end
                ref_mem[idx] = word;
            end else begin
                exp_data = word;
            end
        end
    endfunction

    // Mostly in range at any byte offset and sometimes past the top
    function automatic logic [31:0] pick_addr();
        logic [31:0] a;
        if ($urandom_range(0, 7) == 0) begin
            a = $urandom | TOP_BYTE;
        end else begin
            a = $urandom_range(0, TOP_BYTE - 1);
        end
        return a;
    endfunction

    // All tasks start and end 1 ns after a rising edge
    task automatic send_write(input logic [31:0] addr, data, input logic [3:0] strb);
        int          n;
        logic        hit;
        logic [31:0] ed;
        logic [1:0]  er;
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        wstrb   = strb;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            hit = awready && wready;
        end while (!hit && n < TIMEOUT);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        if (hit) begin
            model_access(1'b1, addr, data, strb, ed, er);
            exp_bresp_q.push_back(er);
        end else begin
            errors++;
            $display("Timeout: write to %h was never accepted", addr);
        end
    endtask

    task automatic send_read(input logic [31:0] addr);
        int          n;
        logic        hit;
        logic [31:0] ed;
        logic [1:0]  er;
        arvalid = 1'b1;
        araddr  = addr;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            hit = arready && !(awvalid && wvalid);    // Write would take this edge
        end while (!hit && n < TIMEOUT);
        #1;
        arvalid = 1'b0;
        if (hit) begin
            model_access(1'b0, addr, '0, '0, ed, er);
            exp_rdata_q.push_back(ed);
            exp_rresp_q.push_back(er);
        end else begin
            errors++;
            $display("Timeout: read of %h was never accepted", addr);
        end
    endtask

    // Wait for B, stall bready for hold cycles, then accept
    task automatic take_b(input int hold);
        int   n;
        logic hit;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            hit = bvalid;
        end while (!hit && n < TIMEOUT);
        if (hit) begin
            repeat (hold) @(posedge clk);
            #1;
            bready = 1'b1;
            @(posedge clk);                 // Handshake edge
        end else begin
            errors++;
            $display("Timeout: no write response arrived");
        end
        #1;
        bready = 1'b0;
    endtask

    task automatic take_r(input int hold);
        int   n;
        logic hit;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            hit = rvalid;
        end while (!hit && n < TIMEOUT);
        if (hit) begin
            repeat (hold) @(posedge clk);
            #1;
            rready = 1'b1;
            @(posedge clk);
        end else begin
            errors++;
            $display("Timeout: no read response arrived");
        end
        #1;
        rready = 1'b0;
    endtask

    task automatic do_write(input logic [31:0] addr, data, input logic [3:0] strb, input int hold);
        send_write(addr, data, strb);
        take_b(hold);
    endtask

    task automatic do_read(input logic [31:0] addr, input int hold);
        send_read(addr);
        take_r(hold);
    endtask

    // All valids at once with the write going first
    task automatic do_both(input logic [31:0] waddr, data, input logic [3:0] strb,
                           input logic [31:0] raddr, input int hold);
        arvalid = 1'b1;
        araddr  = raddr;
        send_write(waddr, data, strb);
        take_b(hold);
        do_read(raddr, hold);
    endtask

    task automatic end_test(input string name);
        $display("%s: done, %0d errors", name, errors - test_errs);
        test_errs = errors;
    endtask

    // Compare process sampling at the rising edge
    always @(posedge clk) begin
        if (rst) begin
            b_stall = 1'b0;
            r_stall = 1'b0;
        end else begin
            checks++;
            assert (!((bvalid || rvalid) && (awready || wready || arready))) else begin
                errors++;
                $display("A ready was high while a response was pending at %0t", $time);
            end
            if (b_stall) begin
                checks++;
                assert (bvalid && bresp == b_hold_resp) else begin
                    errors++;
                    $display("ERR bresp held: got %h expected %h, bvalid %h",
                             bresp, b_hold_resp, bvalid);
                end
            end
            if (r_stall) begin
                checks++;
                assert (rvalid && rdata == r_hold_data && rresp == r_hold_resp) else begin
                    errors++;
                    $display("ERR rdata/rresp held: got %h/%h expected %h/%h, rvalid %h",
                             rdata, rresp, r_hold_data, r_hold_resp, rvalid);
                end
            end
            if (bvalid && bready) begin
                if (exp_bresp_q.size() == 0) begin
                    errors++;
                    $display("A write response arrived with none expected");
                end else begin
                    exp_b = exp_bresp_q.pop_front();
                    checks++;
                    assert (bresp == exp_b) else begin
                        errors++;
                        $display("ERR bresp: got %h expected %h", bresp, exp_b);
                    end
                end
            end
            if (rvalid && rready) begin
                if (exp_rdata_q.size() == 0) begin
                    errors++;
                    $display("A read response arrived with none expected");
                end else begin
                    exp_rd = exp_rdata_q.pop_front();
                    exp_rr = exp_rresp_q.pop_front();
                    checks++;
                    assert (rdata == exp_rd && rresp == exp_rr) else begin
                        errors++;
                        $display("ERR rdata/rresp: got %h/%h expected %h/%h",
                                 rdata, rresp, exp_rd, exp_rr);
                    end
                end
            end
            b_stall     = bvalid && !bready;
            b_hold_resp = bresp;
            r_stall     = rvalid && !rready;
            r_hold_data = rdata;
            r_hold_resp = rresp;
        end
    end

    initial begin
        int          n;
        logic        hit;
        logic        idle_ok;
        int          idx;
        logic [31:0] bad;
        void'($urandom(32'h535c));
        {awvalid, wvalid, bready, arvalid, rready} = '0;
        awaddr    = '0;
        wdata     = '0;
        wstrb     = '0;
        araddr    = '0;
        checks    = 0;
        errors    = 0;
        test_errs = 0;
        rst       = 1'b1;
        repeat (10) @(posedge clk);
        checks++;
        assert (!awready && !wready && !arready) else begin
            errors++;
            $display("A ready was high during reset");
        end
        #1;
        rst = 1'b0;

        // Test 1 checks that readies rise with no response pending
        n = 0;
        do begin
            @(posedge clk);
            n++;
            hit     = awready && wready && arready;
            idle_ok = !bvalid && !rvalid;
        end while (!hit && n < TIMEOUT);
        #1;
        checks += 2;
        assert (hit) else begin
            errors++;
            $display("Timeout: readies did not rise after reset");
        end
        assert (idle_ok) else begin
            errors++;
            $display("A response valid was high right after reset");
        end
        end_test("Test 1 reset");

        // Full words everywhere so every later read has a known word
        for (int i = 0; i < `SRAM_DEPTH; i++) begin
            do_write(i * 4, $urandom, 4'hF, 0);
        end
        for (int i = 0; i < `SRAM_DEPTH; i++) begin
            do_read(i * 4, 0);
        end
        end_test("Test 2 full-word write and read");

        for (int s = 0; s < 16; s++) begin
            idx = $urandom_range(0, `SRAM_DEPTH - 1);
            do_write(idx * 4, $urandom, 4'(s), 0);
            do_read(idx * 4, 0);
        end
        end_test("Test 3 partial strobes");

        for (int k = 0; k < 8; k++) begin
            idx = $urandom_range(0, `SRAM_DEPTH - 1);
            bad = (k < 4) ? TOP_BYTE + idx * 4 : ($urandom | TOP_BYTE);
            do_write(bad, $urandom, 4'hF, 0);
            do_read(bad, 0);
            do_read(idx * 4, 0);            // Aliased word stays unchanged
        end
        end_test("Test 4 out of range");

        for (int k = 0; k < 20; k++) begin
            idx = $urandom_range(0, `SRAM_DEPTH - 1);
            do_write(idx * 4, $urandom, 4'hF, $urandom_range(1, 6));
            do_read(idx * 4, $urandom_range(1, 6));
        end
        end_test("Test 5 back-pressure");

        for (int i = 0; i < 200; i++) begin
            case ($urandom_range(0, 4))
                0, 1: do_write(pick_addr(), $urandom, 4'($urandom_range(0, 15)),
                               $urandom_range(0, 3));
                2, 3: do_read(pick_addr(), $urandom_range(0, 3));
                default: do_both(pick_addr(), $urandom, 4'($urandom_range(0, 15)),
                                 pick_addr(), $urandom_range(0, 3));
            endcase
        end
        end_test("Test 6 random mix");

        checks++;
        assert (exp_bresp_q.size() == 0 && exp_rdata_q.size() == 0) else begin
            errors++;
            $display("Responses still expected at the end of the run");
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+src
src/sram_axi_pkg.sv
src/sram_req_if.sv
src/axi_lite_ctrl.sv
src/sram_latency_timer.sv
src/sram_array.sv
src/sram_axi_top.sv
testbench/tb_sram_axi.sv
